/* msx_glue_pkg.sv */
// MSX glue package with status bit map, widths, constants and bus structs
package msx_glue_pkg;

   // ========================================
   // Host status word layout
   // ========================================
   localparam int STATUS_W       = 64;
   localparam int ST_RESET       = 0;
   localparam int ST_ASPECT_LSB  = 1;
   localparam int ASPECT_W       = 2;
   localparam int ST_SCANDBL_LSB = 3;
   localparam int SCANDBL_W      = 3;
   localparam int ST_SCALE_LSB   = 6;
   localparam int SCALE_W        = 3;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_DETACH      = 10;
   localparam int ST_RESET_MOUNT = 12;
   localparam int ST_RESET_OSD   = 21;
   localparam int ST_TAPE_ADC    = 40;

   // ========================================
   // Image slots, downloads and video
   // ========================================
   // Number of image slots reported by the host
   localparam int IMG_NUM = 7;
   // Slot carrying the virtual SD card
   localparam int SD_SLOT = 4;
   // Cassette download index on the low six bits
   localparam logic [5:0]  CAS_INDEX  = 6'd5;
   localparam logic [11:0] CROP_216   = 12'd216;
   localparam logic [11:0] HDMI_FHD_W = 12'd1920;
   localparam logic [11:0] HDMI_FHD_H = 12'd1080;
   // Data seen by the CPU outside SDRAM
   localparam logic [7:0]  OPEN_BUS   = 8'hFF;

   localparam int RAM_ADDR_W = 27;
   localparam int DDR_ADDR_W = 28;

   // ========================================
   // Bundled signals
   // ========================================
   typedef struct packed {
      logic [11:0] arx;
      logic [11:0] ary;
      logic [11:0] crop_size;
      logic [1:0]  scanline;
      logic [2:0]  scale_mode;
      logic        hq2x;
      logic        scandoubler;
   } video_cfg_t;

   // From the SPI master
   typedef struct packed {
      logic sck;
      logic mosi;
   } spi_t;

   // Card side pins
   typedef struct packed {
      logic cs;
      logic sck;
      logic mosi;
   } sd_pins_t;

   typedef struct packed {
      logic [RAM_ADDR_W-1:0] addr;
      logic [7:0]            din;
      logic                  req;
      logic                  rnw;
   } mem_req_t;

   typedef struct packed {
      logic [DDR_ADDR_W-1:0] addr;
      logic                  rd;
   } ddr_rd_t;

endpackage

/* status_decode.sv */
// Status decoder turning the host status word into core resets and video setup
`timescale 1ns/100ps

module status_decode (
   input  logic                              clock_bus,
   input  logic                              i_arst_n,
   input  logic [msx_glue_pkg::STATUS_W-1:0] i_status,
   input  logic                              i_forced_scandoubler,
   input  logic [11:0]                       i_hdmi_width,
   input  logic [11:0]                       i_hdmi_height,
   input  logic                              i_sd_mount,
   input  logic                              i_disk_ctrl_en,
   input  logic                              i_upload_reset,
   output logic                              o_core_reset,
   output logic                              o_hard_reset,
   output msx_glue_pkg::video_cfg_t          o_video_cfg
);
   import msx_glue_pkg::*;

   logic [ASPECT_W-1:0]  aspect;
   logic [SCANDBL_W-1:0] sd_fx;
   logic [SCANDBL_W-1:0] sd_fx_m1;
   logic                 scandbl_on;
   logic                 fhd_screen;
   logic                 hard_reset_d;
   logic                 core_reset_d;
   video_cfg_t           cfg_d;

   // ========================================
   // Reset sources
   // ========================================
   // Reset pin clears the registers directly and is no source here
   assign hard_reset_d = i_status[ST_RESET] | i_upload_reset;

   assign core_reset_d = hard_reset_d
                       | i_status[ST_DETACH]
                       | i_status[ST_RESET_OSD]
                       | (i_status[ST_RESET_MOUNT] & i_sd_mount & i_disk_ctrl_en);

   // ========================================
   // Video fields
   // ========================================
   assign aspect = i_status[ST_ASPECT_LSB +: ASPECT_W];
   // Scandoubler effect select where 0 is none and 1 is HQ2x
   assign sd_fx  = i_status[ST_SCANDBL_LSB +: SCANDBL_W];

   assign sd_fx_m1   = (sd_fx != '0) ? sd_fx - 3'd1 : 3'd0;
   assign scandbl_on = i_forced_scandoubler | (sd_fx != '0);
   assign fhd_screen = (i_hdmi_width == HDMI_FHD_W) && (i_hdmi_height == HDMI_FHD_H);

   always_comb begin
      cfg_d = '0;
      // Original 4:3 unless a custom ratio slot is chosen
      if (aspect == '0) begin
         cfg_d.arx = 12'd4;
         cfg_d.ary = 12'd3;
      end else begin
         cfg_d.arx = {10'd0, aspect - 2'd1};
         cfg_d.ary = 12'd0;
      end
      cfg_d.scanline    = sd_fx_m1[1:0];
      cfg_d.hq2x        = (sd_fx == 3'd1);
      cfg_d.scandoubler = scandbl_on;
      cfg_d.scale_mode  = i_status[ST_SCALE_LSB +: SCALE_W];
      // 216 line crop only fits 1080p without line doubling
      if (fhd_screen && !scandbl_on) begin
         cfg_d.crop_size = CROP_216;
      end
   end

   // ========================================
   // Output registers
   // ========================================
   always_ff @(posedge clock_bus or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_hard_reset <= 1'b0;
         o_core_reset <= 1'b0;
         o_video_cfg  <= '0;
      end else begin
         o_hard_reset <= hard_reset_d;
         o_core_reset <= core_reset_d;
         o_video_cfg  <= cfg_d;
      end
   end

endmodule

/* sd_path_select.sv */
// SD path selector between physical card and virtual image, with activity LED timing
`timescale 1ns/100ps

module sd_path_select #(
   parameter int ACT_HOLD_CYCLES = 1000000
) (
   input  logic                   clock_bus,
   input  logic                   i_arst_n,
   input  logic                   i_sd_mount,
   input  logic [63:0]            i_img_size,
   input  msx_glue_pkg::spi_t     i_spi,
   input  logic                   i_sd_miso,
   input  logic                   i_vsd_miso,
   output logic                   o_spi_miso,
   output msx_glue_pkg::sd_pins_t o_sd_pins,
   output logic                   o_led_user,
   output logic [1:0]             o_led_disk
);

   logic        vsd_sel;
   logic        mosi_q;
   logic        miso_q;
   logic        spi_toggle;
   logic        sd_active;
   logic [31:0] hold_cnt;

   // ========================================
   // Card select
   // ========================================
   // Non-empty image on the SD slot switches to the virtual card
   always_ff @(posedge clock_bus or negedge i_arst_n) begin
      if (!i_arst_n) begin
         vsd_sel <= 1'b0;
      end else if (i_sd_mount) begin
         vsd_sel <= |i_img_size;
      end
   end

   // Physical pins idle low while the virtual card is used
   assign o_sd_pins.cs   = vsd_sel;
   assign o_sd_pins.sck  = i_spi.sck & ~vsd_sel;
   assign o_sd_pins.mosi = i_spi.mosi & ~vsd_sel;

   assign o_spi_miso = vsd_sel ? i_vsd_miso : i_sd_miso;

   // ========================================
   // Activity detect
   // ========================================
   assign spi_toggle = (mosi_q ^ i_spi.mosi) | (miso_q ^ o_spi_miso);

   // Counter parks at the limit and any data edge restarts the hold time
   always_ff @(posedge clock_bus or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mosi_q   <= 1'b0;
         miso_q   <= 1'b0;
         hold_cnt <= 32'(ACT_HOLD_CYCLES);
      end else begin
         mosi_q <= i_spi.mosi;
         miso_q <= o_spi_miso;
         if (spi_toggle) begin
            hold_cnt <= '0;
         end else if (sd_active) begin
            hold_cnt <= hold_cnt + 32'd1;
         end
      end
   end

   assign sd_active = (hold_cnt < 32'(ACT_HOLD_CYCLES));

   // User LED for the virtual card and disk LED for the physical one
   assign o_led_user = vsd_sel & sd_active;
   assign o_led_disk = {1'b1, ~vsd_sel & sd_active};

endmodule

/* tape_control.sv */
// Cassette control for load completion, play and rewind, and tape input select
`timescale 1ns/100ps

module tape_control (
   input  logic                              clock_bus,
   input  logic                              i_arst_n,
   input  logic                              i_core_reset,
   input  logic [msx_glue_pkg::STATUS_W-1:0] i_status,
   input  logic                              i_ioctl_download,
   input  logic [15:0]                       i_ioctl_index,
   input  logic                              i_tape_motor,
   input  logic                              i_cas_bit,
   input  logic                              i_adc_bit,
   input  logic                              i_adc_active,
   output logic                              o_cas_enable,
   output logic                              o_cas_play,
   output logic                              o_cas_rewind,
   output logic                              o_tape_bit
);
   import msx_glue_pkg::*;

   logic cas_dl;
   logic cas_dl_q;

   // Download in progress carrying a cassette file
   assign cas_dl = i_ioctl_download & (i_ioctl_index[5:0] == CAS_INDEX);

   // ========================================
   // Load completion
   // ========================================
   // Enable latches on the end of the first cassette download
   always_ff @(posedge clock_bus or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cas_dl_q     <= 1'b0;
         o_cas_enable <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q && !cas_dl) begin
            o_cas_enable <= 1'b1;
         end
      end
   end

   // Motor line is active low on the machine side
   assign o_cas_play   = ~i_tape_motor & o_cas_enable;
   assign o_cas_rewind = i_status[ST_TAPE_REWIND] | cas_dl | i_core_reset;

   // ========================================
   // Tape input source
   // ========================================
   assign o_tape_bit = i_status[ST_TAPE_ADC] ? (i_adc_active & i_adc_bit) : i_cas_bit;

endmodule

/* memory_route.sv */
// Memory router for the DDR3 read port, SDRAM channel 1 and CPU read data
`timescale 1ns/100ps

module memory_route (
   input  logic                  i_dl_request,
   input  msx_glue_pkg::ddr_rd_t i_dl_rd,
   input  msx_glue_pkg::ddr_rd_t i_cas_rd,
   input  logic                  i_upload,
   input  msx_glue_pkg::mem_req_t i_upload_req,
   input  msx_glue_pkg::mem_req_t i_cpu_req,
   input  logic                  i_cpu_sdram_ce,
   input  logic [7:0]            i_sdram_dout,
   output msx_glue_pkg::ddr_rd_t o_ddr_rd,
   output msx_glue_pkg::mem_req_t o_sdram_ch1,
   output logic [7:0]            o_cpu_dout
);
   import msx_glue_pkg::*;

   // ========================================
   // DDR3 read port
   // ========================================
   // ROM downloader has priority over the cassette player
   assign o_ddr_rd = i_dl_request ? i_dl_rd : i_cas_rd;

   // ========================================
   // SDRAM channel 1
   // ========================================
   always_comb begin
      if (i_upload) begin
         o_sdram_ch1     = i_upload_req;
         // Uploads only ever write
         o_sdram_ch1.rnw = 1'b0;
      end else begin
         o_sdram_ch1 = i_cpu_req;
      end
   end

   // Open bus outside SDRAM
   assign o_cpu_dout = i_cpu_sdram_ce ? i_sdram_dout : OPEN_BUS;

endmodule

/* msx_glue_top.sv */
// MSX glue top level joining status decode, SD path, tape control and memory routing
`timescale 1ns/100ps

module msx_glue_top #(
   parameter int ACT_HOLD_CYCLES = 1000000
) (
   input  logic                              clock_bus,
   input  logic                              i_arst_n,
   // Host side
   input  logic [msx_glue_pkg::STATUS_W-1:0] i_status,
   input  logic                              i_forced_scandoubler,
   input  logic [11:0]                       i_hdmi_width,
   input  logic [11:0]                       i_hdmi_height,
   input  logic [msx_glue_pkg::IMG_NUM-1:0]  i_img_mounted,
   input  logic [63:0]                       i_img_size,
   input  logic                              i_disk_ctrl_en,
   input  logic                              i_upload_reset,
   // SD card
   input  msx_glue_pkg::spi_t                i_spi,
   input  logic                              i_sd_miso,
   input  logic                              i_vsd_miso,
   // Cassette and tape
   input  logic                              i_ioctl_download,
   input  logic [15:0]                       i_ioctl_index,
   input  logic                              i_tape_motor,
   input  logic                              i_cas_bit,
   input  logic                              i_adc_bit,
   input  logic                              i_adc_active,
   // Memory requests
   input  logic                              i_dl_request,
   input  msx_glue_pkg::ddr_rd_t             i_dl_rd,
   input  msx_glue_pkg::ddr_rd_t             i_cas_rd,
   input  logic                              i_upload,
   input  msx_glue_pkg::mem_req_t            i_upload_req,
   input  msx_glue_pkg::mem_req_t            i_cpu_req,
   input  logic                              i_cpu_sdram_ce,
   input  logic [7:0]                        i_sdram_dout,
   // Outputs
   output logic                              o_core_reset,
   output logic                              o_hard_reset,
   output msx_glue_pkg::video_cfg_t          o_video_cfg,
   output logic                              o_spi_miso,
   output msx_glue_pkg::sd_pins_t            o_sd_pins,
   output logic                              o_led_user,
   output logic [1:0]                        o_led_disk,
   output logic                              o_cas_enable,
   output logic                              o_cas_play,
   output logic                              o_cas_rewind,
   output logic                              o_tape_bit,
   output msx_glue_pkg::ddr_rd_t             o_ddr_rd,
   output msx_glue_pkg::mem_req_t            o_sdram_ch1,
   output logic [7:0]                        o_cpu_dout
);
   import msx_glue_pkg::*;

   logic sd_mount;
   logic core_reset;

   // Host pulses the slot bit for one cycle on mount
   assign sd_mount     = i_img_mounted[SD_SLOT];
   assign o_core_reset = core_reset;

   // ========================================
   // Input side
   // ========================================
   status_decode status_decode_i (
      .clock_bus            (clock_bus),
      .i_arst_n             (i_arst_n),
      .i_status             (i_status),
      .i_forced_scandoubler (i_forced_scandoubler),
      .i_hdmi_width         (i_hdmi_width),
      .i_hdmi_height        (i_hdmi_height),
      .i_sd_mount           (sd_mount),
      .i_disk_ctrl_en       (i_disk_ctrl_en),
      .i_upload_reset       (i_upload_reset),
      .o_core_reset         (core_reset),
      .o_hard_reset         (o_hard_reset),
      .o_video_cfg          (o_video_cfg)
   );

   // ========================================
   // Processing
   // ========================================
   sd_path_select #(
      .ACT_HOLD_CYCLES (ACT_HOLD_CYCLES)
   ) sd_path_select_i (
      .clock_bus  (clock_bus),
      .i_arst_n   (i_arst_n),
      .i_sd_mount (sd_mount),
      .i_img_size (i_img_size),
      .i_spi      (i_spi),
      .i_sd_miso  (i_sd_miso),
      .i_vsd_miso (i_vsd_miso),
      .o_spi_miso (o_spi_miso),
      .o_sd_pins  (o_sd_pins),
      .o_led_user (o_led_user),
      .o_led_disk (o_led_disk)
   );

   tape_control tape_control_i (
      .clock_bus        (clock_bus),
      .i_arst_n         (i_arst_n),
      .i_core_reset     (core_reset),
      .i_status         (i_status),
      .i_ioctl_download (i_ioctl_download),
      .i_ioctl_index    (i_ioctl_index),
      .i_tape_motor     (i_tape_motor),
      .i_cas_bit        (i_cas_bit),
      .i_adc_bit        (i_adc_bit),
      .i_adc_active     (i_adc_active),
      .o_cas_enable     (o_cas_enable),
      .o_cas_play       (o_cas_play),
      .o_cas_rewind     (o_cas_rewind),
      .o_tape_bit       (o_tape_bit)
   );

   // ========================================
   // Output side
   // ========================================
   memory_route memory_route_i (
      .i_dl_request   (i_dl_request),
      .i_dl_rd        (i_dl_rd),
      .i_cas_rd       (i_cas_rd),
      .i_upload       (i_upload),
      .i_upload_req   (i_upload_req),
      .i_cpu_req      (i_cpu_req),
      .i_cpu_sdram_ce (i_cpu_sdram_ce),
      .i_sdram_dout   (i_sdram_dout),
      .o_ddr_rd       (o_ddr_rd),
      .o_sdram_ch1    (o_sdram_ch1),
      .o_cpu_dout     (o_cpu_dout)
   );

endmodule

/* msx_glue_props.sv */
// Concurrent assertions on cassette enable, upload writes and SD card select
`timescale 1ns/100ps

module msx_glue_props (
   input logic clock_bus,
   input logic i_arst_n,
   input logic i_upload,
   input logic i_ch1_rnw,
   input logic i_cas_enable,
   input logic i_sd_cs,
   input logic i_sd_mount
);

   // ========================================
   // Cassette
   // ========================================
   // Enable is sticky until the reset pin
   cas_enable_sticky: assert property (
      @(posedge clock_bus) disable iff (!i_arst_n)
      !$fell(i_cas_enable)
   ) else $error("cassette enable fell while out of reset");

   // ========================================
   // Memory and SD card
   // ========================================
   upload_writes_only: assert property (
      @(posedge clock_bus) disable iff (!i_arst_n)
      i_upload |-> !i_ch1_rnw
   ) else $error("SDRAM channel 1 read request during upload");

   // Card select only moves right after a mount
   sd_cs_on_mount: assert property (
      @(posedge clock_bus) disable iff (!i_arst_n)
      $changed(i_sd_cs) |-> $past(i_sd_mount)
   ) else $error("SD cs changed without a mount pulse");

endmodule

/* tb_msx_glue.sv */
// Directed testbench for the MSX glue top level
`timescale 1ns/100ps

module tb_msx_glue;
   import msx_glue_pkg::*;

   localparam int HOLD        = 64;
   localparam int TEST_CYCLES = 600;
   // Three times the expected test length plus slack
   localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 + 200;

   logic                clock_bus = 1'b0;
   logic                i_arst_n;
   logic [STATUS_W-1:0] i_status;
   logic                i_forced_scandoubler;
   logic                i_disk_ctrl_en;
   logic                i_upload_reset;
   logic [11:0]         i_hdmi_width;
   logic [11:0]         i_hdmi_height;
   logic [IMG_NUM-1:0]  i_img_mounted;
   logic [63:0]         i_img_size;
   spi_t                i_spi;
   logic                i_sd_miso;
   logic                i_vsd_miso;
   logic                i_ioctl_download;
   logic                i_tape_motor;
   logic [15:0]         i_ioctl_index;
   logic                i_cas_bit;
   logic                i_adc_bit;
   logic                i_adc_active;
   logic                i_dl_request;
   logic                i_upload;
   logic                i_cpu_sdram_ce;
   ddr_rd_t             i_dl_rd;
   ddr_rd_t             i_cas_rd;
   ddr_rd_t             o_ddr_rd;
   mem_req_t            i_upload_req;
   mem_req_t            i_cpu_req;
   mem_req_t            o_sdram_ch1;
   logic [7:0]          i_sdram_dout;
   logic [7:0]          o_cpu_dout;
   logic                o_core_reset;
   logic                o_hard_reset;
   logic                o_spi_miso;
   logic                o_led_user;
   video_cfg_t          o_video_cfg;
   sd_pins_t            o_sd_pins;
   logic [1:0]          o_led_disk;
   logic                o_cas_enable;
   logic                o_cas_play;
   logic                o_cas_rewind;
   logic                o_tape_bit;

   int errors = 0;
   int tests  = 0;
   int cycles = 0;

   msx_glue_top #(.ACT_HOLD_CYCLES(HOLD)) dut_i (.*);

   bind msx_glue_top msx_glue_props props_i (
      .clock_bus    (clock_bus),
      .i_arst_n     (i_arst_n),
      .i_upload     (i_upload),
      .i_ch1_rnw    (o_sdram_ch1.rnw),
      .i_cas_enable (o_cas_enable),
      .i_sd_cs      (o_sd_pins.cs),
      .i_sd_mount   (sd_mount)
   );

   always #5 clock_bus = ~clock_bus;

   // ========================================
   // Run limit
   // ========================================
   always @(posedge clock_bus) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run stopped by the cycle limit after %0d cycles", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
      $display("[ERROR] %s got %0h expected %0h", name, got, expected);
      errors++;
   endtask

   task automatic close_test(input string name, input int errors_before);
      tests++;
      $display("Test %-14s %0d errors", name, errors - errors_before);
   endtask

   // ========================================
   // Resets
   // ========================================
   task automatic drive_reset_case(input logic [STATUS_W-1:0] st, input logic up_rst,
                                   input logic mount, input logic disk,
                                   input logic exp_core, input logic exp_hard);
      @(posedge clock_bus);
      i_status       <= st;
      i_upload_reset <= up_rst;
      i_img_mounted  <= mount ? (IMG_NUM'(1) << SD_SLOT) : '0;
      i_disk_ctrl_en <= disk;
      @(posedge clock_bus);
      i_status       <= '0;
      i_upload_reset <= 1'b0;
      i_img_mounted  <= '0;
      i_disk_ctrl_en <= 1'b0;
      @(negedge clock_bus);
      if (o_core_reset !== exp_core) report_mismatch("o_core_reset", o_core_reset, exp_core);
      if (o_hard_reset !== exp_hard) report_mismatch("o_hard_reset", o_hard_reset, exp_hard);
   endtask

   task automatic pulse_reset_sources();
      int e0;
      e0 = errors;
      drive_reset_case(64'd1 << ST_RESET, 0, 0, 0, 1, 1);
      drive_reset_case(64'd1 << ST_DETACH, 0, 0, 0, 1, 0);
      drive_reset_case(64'd1 << ST_RESET_OSD, 0, 0, 0, 1, 0);
      drive_reset_case('0, 1, 0, 0, 1, 1);
      // Reset after mount needs all three conditions
      drive_reset_case(64'd1 << ST_RESET_MOUNT, 0, 1, 0, 0, 0);
      drive_reset_case(64'd1 << ST_RESET_MOUNT, 0, 0, 1, 0, 0);
      drive_reset_case('0, 0, 1, 1, 0, 0);
      drive_reset_case(64'd1 << ST_RESET_MOUNT, 0, 1, 1, 1, 0);
      close_test("resets", e0);
   endtask

   // ========================================
   // Video configuration
   // ========================================
   task automatic check_video(input logic [1:0] asp, input logic [2:0] fx, input logic forced,
                              input logic [11:0] w, input logic [11:0] h);
      video_cfg_t exp_cfg;
      logic [2:0] scale;
      scale = 3'($urandom);
      exp_cfg = '0;
      exp_cfg.arx         = (asp == 2'd0) ? 12'd4 : 12'(asp) - 12'd1;
      exp_cfg.ary         = (asp == 2'd0) ? 12'd3 : 12'd0;
      exp_cfg.scanline    = (fx == 3'd0) ? 2'd0 : 2'(fx - 3'd1);
      exp_cfg.hq2x        = (fx == 3'd1);
      exp_cfg.scandoubler = forced || (fx != 3'd0);
      exp_cfg.scale_mode  = scale;
      if (w == 12'd1920 && h == 12'd1080 && !exp_cfg.scandoubler) begin
         exp_cfg.crop_size = 12'd216;
      end
      @(posedge clock_bus);
      i_status <= (64'(asp) << ST_ASPECT_LSB) | (64'(fx) << ST_SCANDBL_LSB)
                | (64'(scale) << ST_SCALE_LSB);
      i_forced_scandoubler <= forced;
      i_hdmi_width         <= w;
      i_hdmi_height        <= h;
      @(posedge clock_bus);
      @(negedge clock_bus);
      if (o_video_cfg !== exp_cfg) report_mismatch("o_video_cfg", o_video_cfg, exp_cfg);
   endtask

   task automatic sweep_video_modes();
      int e0;
      e0 = errors;
      for (int a = 0; a < 4; a++) begin
         for (int f = 0; f < 8; f++) begin
            check_video(2'(a), 3'(f), 1'b0, 12'd1920, 12'd1080);
         end
      end
      check_video(2'd0, 3'd0, 1'b1, 12'd1920, 12'd1080);
      check_video(2'd0, 3'd0, 1'b0, 12'd1280, 12'd720);
      check_video(2'd0, 3'd0, 1'b0, 12'd1920, 12'd1200);
      @(posedge clock_bus);
      i_status <= '0;
      close_test("video", e0);
   endtask

   // ========================================
   // SD path and activity LEDs
   // ========================================
   task automatic mount_sd(input logic [63:0] size);
      @(posedge clock_bus);
      i_img_size    <= size;
      i_img_mounted <= IMG_NUM'(1) << SD_SLOT;
      @(posedge clock_bus);
      i_img_mounted <= '0;
   endtask

   task automatic check_sd_pins(input logic sel);
      logic [3:0] v;
      sd_pins_t   exp_pins;
      for (int k = 0; k < 16; k++) begin
         v = 4'(k);
         @(posedge clock_bus);
         i_spi      <= v[1:0];
         i_sd_miso  <= v[2];
         i_vsd_miso <= v[3];
         @(negedge clock_bus);
         exp_pins.cs   = sel;
         exp_pins.sck  = v[1] & ~sel;
         exp_pins.mosi = v[0] & ~sel;
         if (o_sd_pins !== exp_pins) report_mismatch("o_sd_pins", o_sd_pins, exp_pins);
         if (o_spi_miso !== (sel ? v[3] : v[2])) begin
            report_mismatch("o_spi_miso", o_spi_miso, sel ? v[3] : v[2]);
         end
      end
   endtask

   // Image size changes without a mount leave the card select alone
   task automatic check_select_hold(input logic sel, input logic [63:0] size);
      @(posedge clock_bus);
      i_img_size <= size;
      repeat (2) @(posedge clock_bus);
      @(negedge clock_bus);
      if (o_sd_pins.cs !== sel) report_mismatch("o_sd_pins.cs", o_sd_pins.cs, sel);
   endtask

   task automatic switch_sd_card();
      int e0;
      e0 = errors;
      mount_sd({$urandom, $urandom} | 64'd1);
      check_sd_pins(1'b1);
      check_select_hold(1'b1, 64'd0);
      mount_sd(64'd0);
      check_sd_pins(1'b0);
      check_select_hold(1'b0, {$urandom, $urandom} | 64'd1);
      close_test("sd path", e0);
   endtask

   task automatic wait_led_dark();
      int n;
      n = 0;
      @(negedge clock_bus);
      while ((o_led_user || o_led_disk[0]) && n < HOLD + 2) begin
         @(negedge clock_bus);
         n++;
      end
      if (o_led_user || o_led_disk[0]) begin
         $display("Activity LED still lit %0d cycles after the last SPI toggle", n);
         errors++;
      end
      if (o_led_disk[1] !== 1'b1) report_mismatch("o_led_disk", o_led_disk, 2'b10);
   endtask

   task automatic toggle_mosi(input logic sel);
      @(posedge clock_bus);
      i_spi.mosi <= ~i_spi.mosi;
      @(posedge clock_bus);
      @(negedge clock_bus);
      if (o_led_user !== sel) report_mismatch("o_led_user", o_led_user, sel);
      if (o_led_disk !== {1'b1, ~sel}) report_mismatch("o_led_disk", o_led_disk, {1'b1, ~sel});
      wait_led_dark();
   endtask

   task automatic watch_activity_leds();
      int e0;
      e0 = errors;
      @(posedge clock_bus);
      i_spi      <= '0;
      i_sd_miso  <= 1'b0;
      i_vsd_miso <= 1'b0;
      wait_led_dark();
      toggle_mosi(1'b0);
      mount_sd({$urandom, $urandom} | 64'd1);
      toggle_mosi(1'b1);
      mount_sd(64'd0);
      close_test("leds", e0);
   endtask

   // ========================================
   // Cassette and tape
   // ========================================
   task automatic run_download(input logic [15:0] idx, input logic exp_en);
      @(posedge clock_bus);
      i_ioctl_download <= 1'b1;
      i_ioctl_index    <= idx;
      @(negedge clock_bus);
      if (o_cas_rewind !== (idx[5:0] == 6'd5)) begin
         report_mismatch("o_cas_rewind", o_cas_rewind, idx[5:0] == 6'd5);
      end
      if (o_cas_enable !== 1'b0) report_mismatch("o_cas_enable", o_cas_enable, 1'b0);
      repeat (3) @(posedge clock_bus);
      i_ioctl_download <= 1'b0;
      @(posedge clock_bus);
      @(negedge clock_bus);
      if (o_cas_enable !== exp_en) report_mismatch("o_cas_enable", o_cas_enable, exp_en);
   endtask

   task automatic exercise_tape();
      int e0;
      logic [2:0] v;
      e0 = errors;
      run_download({10'($urandom), 6'd3}, 1'b0);
      run_download({10'($urandom), 6'd5}, 1'b1);
      @(posedge clock_bus);
      i_tape_motor <= 1'b0;
      @(negedge clock_bus);
      if (o_cas_play !== 1'b1) report_mismatch("o_cas_play", o_cas_play, 1'b1);
      @(posedge clock_bus);
      i_tape_motor <= 1'b1;
      i_status     <= 64'd1 << ST_TAPE_REWIND;
      @(negedge clock_bus);
      if (o_cas_play !== 1'b0) report_mismatch("o_cas_play", o_cas_play, 1'b0);
      if (o_cas_rewind !== 1'b1) report_mismatch("o_cas_rewind", o_cas_rewind, 1'b1);
      @(posedge clock_bus);
      i_status <= '0;
      @(negedge clock_bus);
      if (o_cas_rewind !== 1'b0) report_mismatch("o_cas_rewind", o_cas_rewind, 1'b0);
      // Core reset rewinds the tape but keeps the player enabled
      @(posedge clock_bus);
      i_status <= 64'd1 << ST_DETACH;
      @(posedge clock_bus);
      i_status <= '0;
      @(negedge clock_bus);
      if (o_cas_rewind !== 1'b1) report_mismatch("o_cas_rewind", o_cas_rewind, 1'b1);
      if (o_cas_enable !== 1'b1) report_mismatch("o_cas_enable", o_cas_enable, 1'b1);
      for (int k = 0; k < 8; k++) begin
         v = 3'(k);
         @(posedge clock_bus);
         i_status     <= 64'(v[2]) << ST_TAPE_ADC;
         i_adc_active <= v[1];
         i_adc_bit    <= v[0];
         i_cas_bit    <= ~v[0];
         @(negedge clock_bus);
         if (o_tape_bit !== (v[2] ? (v[1] & v[0]) : ~v[0])) begin
            report_mismatch("o_tape_bit", o_tape_bit, v[2] ? (v[1] & v[0]) : ~v[0]);
         end
      end
      @(posedge clock_bus);
      i_status <= '0;
      close_test("tape", e0);
   endtask

   // ========================================
   // Memory routing
   // ========================================
   task automatic route_random_requests();
      int          e0;
      logic [63:0] r0;
      logic [63:0] r1;
      logic [63:0] r2;
      ddr_rd_t     dl;
      ddr_rd_t     cas;
      ddr_rd_t     exp_ddr;
      mem_req_t    up;
      mem_req_t    cpu;
      mem_req_t    exp_ch1;
      logic [7:0]  dout;
      e0 = errors;
      for (int k = 0; k < 16; k++) begin
         r0 = {$urandom, $urandom};
         r1 = {$urandom, $urandom};
         r2 = {$urandom, $urandom};
         dl      = r0[28:0];
         cas     = r0[60:32];
         up      = r1[36:0];
         cpu     = r2[36:0];
         dout    = r2[47:40];
         exp_ddr = k[0] ? dl : cas;
         exp_ch1 = k[1] ? up : cpu;
         if (k[1]) begin
            exp_ch1.rnw = 1'b0;
         end
         @(posedge clock_bus);
         i_dl_request   <= k[0];
         i_upload       <= k[1];
         i_cpu_sdram_ce <= k[2];
         i_dl_rd        <= dl;
         i_cas_rd       <= cas;
         i_upload_req   <= up;
         i_cpu_req      <= cpu;
         i_sdram_dout   <= dout;
         @(negedge clock_bus);
         if (o_ddr_rd !== exp_ddr) report_mismatch("o_ddr_rd", o_ddr_rd, exp_ddr);
         if (o_sdram_ch1 !== exp_ch1) report_mismatch("o_sdram_ch1", o_sdram_ch1, exp_ch1);
         if (o_cpu_dout !== (k[2] ? dout : 8'hFF)) begin
            report_mismatch("o_cpu_dout", o_cpu_dout, k[2] ? dout : 8'hFF);
         end
      end
      @(posedge clock_bus);
      i_upload <= 1'b0;
      close_test("memory", e0);
   endtask

   initial begin
      void'($urandom(32'hdab5));
      i_arst_n             = 1'b0;
      i_status             = '0;
      i_forced_scandoubler = 1'b0;
      i_hdmi_width         = '0;
      i_hdmi_height        = '0;
      i_img_mounted        = '0;
      i_img_size           = '0;
      i_disk_ctrl_en       = 1'b0;
      i_upload_reset       = 1'b0;
      i_spi                = '0;
      i_sd_miso            = 1'b0;
      i_vsd_miso           = 1'b0;
      i_ioctl_download     = 1'b0;
      i_ioctl_index        = '0;
      i_tape_motor         = 1'b1;
      i_cas_bit            = 1'b0;
      i_adc_bit            = 1'b0;
      i_adc_active         = 1'b0;
      i_dl_request         = 1'b0;
      i_dl_rd              = '0;
      i_cas_rd             = '0;
      i_upload             = 1'b0;
      i_upload_req         = '0;
      i_cpu_req            = '0;
      i_cpu_sdram_ce       = 1'b0;
      i_sdram_dout         = '0;
      repeat (10) @(posedge clock_bus);
      i_arst_n <= 1'b1;
      @(posedge clock_bus);
      pulse_reset_sources();
      sweep_video_modes();
      switch_sd_card();
      watch_activity_leds();
      exercise_tape();
      route_random_requests();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* vlog.f */
msx_glue_pkg.sv
status_decode.sv
sd_path_select.sv
tape_control.sv
memory_route.sv
msx_glue_top.sv
msx_glue_props.sv
tb_msx_glue.sv

/* Bender.yml */
package:
  name: msx_glue

sources:
  - msx_glue_pkg.sv
  - status_decode.sv
  - sd_path_select.sv
  - tape_control.sv
  - memory_route.sv
  - msx_glue_top.sv
  - target: test
    files:
      - msx_glue_props.sv
      - tb_msx_glue.sv
